/* Makefile */
VERILATOR ?= verilator
TOP       ?= signDot_tb
FILELIST  ?= signDot.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/adderTree.sv */
`timescale 1ns/100ps
`default_nettype none

`include "signDot_params.svh"

module adderTree import signDotPkg::*; (
    input  logic     clk,
    input  logic     rstPulse,
    input  fixWord_t groupSums [`GROUPS_PER_STEP],
    output fixWord_t treeSum
);
    localparam int Inputs = `GROUPS_PER_STEP;
    localparam int Layers = `TREE_LAYERS;

    // Node count on a given layer, layer 0 being the inputs
    function automatic int nodeCount(int layer);
        int n;
        n = Inputs;
        for (int i = 0; i < layer; i++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    fixWord_t node [Layers+1][Inputs];

    for (genvar k = 0; k < Inputs; k++) begin : gInput
        assign node[0][k] = groupSums[k];
    end

    for (genvar l = 0; l < Layers; l++) begin : gLayer
        for (genvar k = 0; k < nodeCount(l + 1); k++) begin : gNode
            if (2 * k + 1 < nodeCount(l)) begin : gAdd
                fixAdd pairAdd (
                    .clk      (clk),
                    .rstPulse (rstPulse),
                    .addendA  (node[l][2*k]),
                    .addendB  (node[l][2*k+1]),
                    .sum      (node[l+1][k])
                );
            end else begin : gPass
                // Odd node waits a cycle to stay in step with its layer
                always_ff @(posedge clk or posedge rstPulse) begin
                    if (rstPulse) begin
                        node[l+1][k] <= '0;
                    end else begin
                        node[l+1][k] <= node[l][2*k];
                    end
                end
            end
        end
    end

    assign treeSum = node[Layers][0];

endmodule

`default_nettype wire

/* hw/cumulativeAcc.sv */
`timescale 1ns/100ps
`default_nettype none

`include "signDot_params.svh"

module cumulativeAcc import signDotPkg::*; (
    input  logic                                      clk,
    input  logic                                      rstPulse,
    input  logic                                      startReq,
    input  logic [`COEF_COUNT-1:0]                    sel,
    output logic [`GROUPS_PER_STEP-1:0][`LUT_SIZE-1:0] groupSel,
    output logic [`STEP_BITS-1:0]                     lutBank,
    input  fixWord_t                                  treeSum,
    output logic                                      busy,
    output logic                                      doneAck,
    output fixWord_t                                  result
);
    localparam int StepBits = `STEP_BITS;
    localparam int TreeLat = `TREE_LAYERS;
    localparam int PipeLen = TreeLat + 1;
    localparam logic [StepBits-1:0] LastStep = StepBits'(`STEP_COUNT - 1);

    logic [`COEF_COUNT-1:0] selReg;
    logic                   accept;
    logic                   issuing;
    logic                   accDone;
    logic                   treeVld;
    logic [StepBits-1:0]    issueCnt;
    logic [StepBits-1:0]    arriveCnt;
    logic [PipeLen-1:0]     vldPipe;
    fixWord_t               accIn;
    fixWord_t               accSum;

    // New compute only after the previous return phase has closed
    assign accept = startReq && !doneAck && !busy;

    // Bit 0 marks a valid groupSel, the top bit a valid treeSum
    assign treeVld = vldPipe[TreeLat];

    always_ff @(posedge clk) begin
        if (accept) begin
            selReg <= sel;
        end
    end

    // Issue stage, one step per cycle
    always_ff @(posedge clk or posedge rstPulse) begin
        if (rstPulse) begin
            busy     <= 1'b0;
            issuing  <= 1'b0;
            issueCnt <= '0;
            groupSel <= '0;
            lutBank  <= '0;
            vldPipe  <= '0;
        end else begin
            vldPipe <= (vldPipe << 1) | PipeLen'(issuing);
            if (accept) begin
                busy     <= 1'b1;
                issuing  <= 1'b1;
                issueCnt <= '0;
            end else if (issuing) begin
                for (int g = 0; g < `GROUPS_PER_STEP; g++) begin
                    groupSel[g] <= selReg[(int'(issueCnt) * `GROUPS_PER_STEP + g) *
                                          `LUT_SIZE +: `LUT_SIZE];
                end
                lutBank <= issueCnt;
                if (issueCnt == LastStep) begin
                    issuing <= 1'b0;
                end else begin
                    issueCnt <= issueCnt + 1'b1;
                end
            end
            if (accDone) begin
                busy <= 1'b0;
            end
        end
    end

    // First step sum starts from zero
    assign accIn = (arriveCnt == '0) ? '0 : accSum;

    fixAdd stepAdd (
        .clk      (clk),
        .rstPulse (rstPulse),
        .addendA  (treeSum),
        .addendB  (accIn),
        .sum      (accSum)
    );

    // Count tree outputs, then publish and run the return phase
    always_ff @(posedge clk or posedge rstPulse) begin
        if (rstPulse) begin
            arriveCnt <= '0;
            accDone   <= 1'b0;
            doneAck   <= 1'b0;
            result    <= '0;
        end else begin
            accDone <= 1'b0;
            if (treeVld) begin
                if (arriveCnt == LastStep) begin
                    arriveCnt <= '0;
                    accDone   <= 1'b1;
                end else begin
                    arriveCnt <= arriveCnt + 1'b1;
                end
            end
            if (accDone) begin
                result  <= accSum;
                doneAck <= 1'b1;
            end else if (doneAck && !startReq) begin
                doneAck <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fixAdd.sv */
`timescale 1ns/100ps
`default_nettype none

module fixAdd import signDotPkg::*; (
    input  logic     clk,
    input  logic     rstPulse,
    input  fixWord_t addendA,
    input  fixWord_t addendB,
    output fixWord_t sum
);
    localparam int W = $bits(fixWord_t);

    logic signed [W:0] wide;
    fixWord_t          clamped;

    // One extra bit catches the carry out of the sign
    assign wide = addendA + addendB;

    always_comb begin
        if (wide[W] == wide[W-1]) begin
            clamped = wide[W-1:0];
        end else if (wide[W]) begin
            clamped = {1'b1, {(W-1){1'b0}}};
        end else begin
            clamped = {1'b0, {(W-1){1'b1}}};
        end
    end

    always_ff @(posedge clk or posedge rstPulse) begin
        if (rstPulse) begin
            sum <= '0;
        end else begin
            sum <= clamped;
        end
    end

endmodule

`default_nettype wire

/* hw/signDotPkg.sv */
`default_nettype none

`include "signDot_params.svh"

package signDotPkg;

    // Coefficients, group sums, tree sums and result
    typedef logic signed [`FIX_WIDTH-1:0] fixWord_t;

    // Table entry with headroom for a full group sum
    typedef logic signed [`FIX_WIDTH+`GUARD_BITS-1:0] lutEntry_t;

    typedef logic [$clog2(`COEF_COUNT)-1:0] coefIndex_t;

endpackage

`default_nettype wire

/* hw/signDotTop.sv */
`timescale 1ns/100ps
`default_nettype none

`include "signDot_params.svh"

module signDotTop import signDotPkg::*; (
    input  logic                   clk,
    input  logic                   rstPulse,
    input  logic                   coefReq,
    input  coefIndex_t             coefIndex,
    input  fixWord_t               coefData,
    output logic                   coefAck,
    input  logic                   startReq,
    input  logic [`COEF_COUNT-1:0] sel,
    output logic                   doneAck,
    output fixWord_t               result
);
    localparam int LutCount = `COEF_COUNT / `LUT_SIZE;
    localparam int SlotBits = $clog2(`LUT_SIZE);
    localparam int BankBits = $bits(coefIndex_t) - SlotBits;

    logic                                      busy;
    logic                                      coefWrite;
    logic [BankBits-1:0]                       coefBank;
    logic [`GROUPS_PER_STEP-1:0][`LUT_SIZE-1:0] groupSel;
    logic [`STEP_BITS-1:0]                     lutBank;
    fixWord_t                                  lutSums [LutCount];
    fixWord_t                                  groupSums [`GROUPS_PER_STEP];
    fixWord_t                                  treeSum;

    // Writes wait while a compute is reading the tables
    assign coefWrite = coefReq && !coefAck && !busy;
    assign coefBank  = coefIndex[$bits(coefIndex_t)-1:SlotBits];

    always_ff @(posedge clk or posedge rstPulse) begin
        if (rstPulse) begin
            coefAck <= 1'b0;
        end else if (coefWrite) begin
            coefAck <= 1'b1;
        end else if (coefAck && !coefReq) begin
            coefAck <= 1'b0;
        end
    end

    for (genvar l = 0; l < LutCount; l++) begin : gLut
        signLut lut (
            .clk      (clk),
            .rstPulse (rstPulse),
            .lutWrite (coefWrite && (coefBank == BankBits'(l))),
            .coefSlot (coefIndex[SlotBits-1:0]),
            .coefData (coefData),
            .groupSel (groupSel[l % `GROUPS_PER_STEP]),
            .groupSum (lutSums[l])
        );
    end

    // Current bank picks which tables feed the tree
    always_comb begin
        for (int g = 0; g < `GROUPS_PER_STEP; g++) begin
            groupSums[g] = lutSums[int'(lutBank) * `GROUPS_PER_STEP + g];
        end
    end

    adderTree tree (
        .clk       (clk),
        .rstPulse  (rstPulse),
        .groupSums (groupSums),
        .treeSum   (treeSum)
    );

    cumulativeAcc acc (
        .clk      (clk),
        .rstPulse (rstPulse),
        .startReq (startReq),
        .sel      (sel),
        .groupSel (groupSel),
        .lutBank  (lutBank),
        .treeSum  (treeSum),
        .busy     (busy),
        .doneAck  (doneAck),
        .result   (result)
    );

endmodule

`default_nettype wire

/* hw/signDot_params.svh */
`ifndef SIGNDOT_PARAMS_SVH
`define SIGNDOT_PARAMS_SVH

// Fixed-point format, sign bit included in the width
`define FIX_INT          8
`define FIX_FRAC         7
`define FIX_WIDTH        (`FIX_INT + `FIX_FRAC + 1)
`define GUARD_BITS       2

// Sign bits per table and table grouping
`define LUT_SIZE         4
`define COEF_COUNT       16
`define GROUPS_PER_STEP  2
`define STEP_COUNT       (`COEF_COUNT / (`LUT_SIZE * `GROUPS_PER_STEP))

// Derived widths for step counters and tree depth
`define STEP_BITS        ((`STEP_COUNT > 1) ? $clog2(`STEP_COUNT) : 1)
`define TREE_LAYERS      $clog2(`GROUPS_PER_STEP)

`endif

/* hw/signLut.sv */
`timescale 1ns/100ps
`default_nettype none

`include "signDot_params.svh"

module signLut import signDotPkg::*; (
    input  logic                         clk,
    input  logic                         rstPulse,
    input  logic                         lutWrite,
    input  logic [$clog2(`LUT_SIZE)-1:0] coefSlot,
    input  fixWord_t                     coefData,
    input  logic [`LUT_SIZE-1:0]         groupSel,
    output fixWord_t                     groupSum
);
    localparam int Entries = 2 ** `LUT_SIZE;
    localparam int EntryWidth = $bits(lutEntry_t);

    fixWord_t  coefs [`LUT_SIZE];
    lutEntry_t signTable [Entries];
    lutEntry_t delta;
    lutEntry_t entry;
    logic      fits;
    logic      wrapped;

    // Change of the written coefficient in entry format
    assign delta = lutEntry_t'(coefData) - lutEntry_t'(coefs[coefSlot]);

    // Each entry moves by +delta or -delta depending on its bit for the slot
    always_ff @(posedge clk or posedge rstPulse) begin
        if (rstPulse) begin
            for (int s = 0; s < `LUT_SIZE; s++) begin
                coefs[s] <= '0;
            end
            for (int i = 0; i < Entries; i++) begin
                signTable[i] <= '0;
            end
        end else if (lutWrite) begin
            coefs[coefSlot] <= coefData;
            for (int i = 0; i < Entries; i++) begin
                if (i[coefSlot]) begin
                    signTable[i] <= signTable[i] + delta;
                end else begin
                    signTable[i] <= signTable[i] - delta;
                end
            end
        end
    end

    assign entry = signTable[groupSel];

    assign fits = (entry[EntryWidth-1:`FIX_WIDTH-1] == '0) ||
                  (entry[EntryWidth-1:`FIX_WIDTH-1] == '1);

    // Entry 0 reaches the bottom code only by wrapping from minus four minimums
    assign wrapped = (groupSel == '0) &&
                     (entry == {1'b1, {(EntryWidth-1){1'b0}}});

    always_comb begin
        if (fits) begin
            groupSum = entry[`FIX_WIDTH-1:0];
        end else if (entry[EntryWidth-1] && !wrapped) begin
            groupSum = {1'b1, {(`FIX_WIDTH-1){1'b0}}};
        end else begin
            groupSum = {1'b0, {(`FIX_WIDTH-1){1'b1}}};
        end
    end

endmodule

`default_nettype wire

/* signDot.f */
+incdir+hw
hw/signDotPkg.sv
hw/signLut.sv
hw/fixAdd.sv
hw/adderTree.sv
hw/cumulativeAcc.sv
hw/signDotTop.sv
verification/signDot_sva.sv
verification/signDot_tb.sv

/* verification/signDot_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module signDot_sva import signDotPkg::*; (
    input logic     clk,
    input logic     rstPulse,
    input logic     coefReq,
    input logic     coefAck,
    input logic     startReq,
    input logic     doneAck,
    input logic     busy,
    input fixWord_t result
);
    logic accepted;
    logic computing;

    assign accepted = startReq && !doneAck && !busy;

    // Req up and ack not yet back marks a compute in flight
    assign computing = startReq && !doneAck;

    coefAckNeedsReq: assert property (@(posedge clk) disable iff (rstPulse)
        $rose(coefAck) |-> $past(coefReq))
        else $error("coefAck rose without coefReq");

    doneAckNeedsReq: assert property (@(posedge clk) disable iff (rstPulse)
        $rose(doneAck) |-> $past(startReq))
        else $error("doneAck rose without startReq");

    // Rise lands five edges after the accepting edge, seen one sample later
    doneLatency: assert property (@(posedge clk) disable iff (rstPulse)
        $past(accepted, 6) |-> $rose(doneAck))
        else $error("doneAck late after an accepted compute");

    doneOnlyAfterAccept: assert property (@(posedge clk) disable iff (rstPulse)
        $rose(doneAck) |-> $past(accepted, 6))
        else $error("doneAck rose without a compute accepted five edges before");

    resultStable: assert property (@(posedge clk) disable iff (rstPulse)
        doneAck && $past(doneAck) |-> $stable(result))
        else $error("result changed while doneAck was high");

    // No write lands between the accepting edge and the rise of doneAck
    noCoefAckWhileBusy: assert property (@(posedge clk) disable iff (rstPulse)
        $rose(coefAck) |-> !($past(computing) && $past(computing, 2)))
        else $error("coefAck rose during a busy compute");

endmodule

bind signDotTop signDot_sva sva (
    .clk      (clk),
    .rstPulse (rstPulse),
    .coefReq  (coefReq),
    .coefAck  (coefAck),
    .startReq (startReq),
    .doneAck  (doneAck),
    .busy     (busy),
    .result   (result)
);

`default_nettype wire

/* verification/signDot_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "signDot_params.svh"

module signDot_tb import signDotPkg::*; ();
    localparam int SmallCount = 200;
    localparam int LimitCount = 40;
    localparam int RewriteCount = 60;
    localparam int BackCount = 100;
    localparam int BusyCount = 20;
    localparam int OpCount = 3 + 3 * `COEF_COUNT + SmallCount + LimitCount +
                             2 * RewriteCount + BackCount + 3 * BusyCount;
    localparam int HandshakeLimit = 20;
    localparam int MaxWord = 2 ** (`FIX_WIDTH - 1) - 1;
    localparam int MinWord = -MaxWord - 1;

    logic                   clk = 1'b0;
    logic                   rstPulse;
    logic                   coefReq;
    coefIndex_t             coefIndex;
    fixWord_t               coefData;
    logic                   coefAck;
    logic                   startReq;
    logic [`COEF_COUNT-1:0] sel;
    logic                   doneAck;
    fixWord_t               result;

    fixWord_t    coefModel [`COEF_COUNT];
    logic [31:0] rngState = 32'd55;
    int          errorCount = 0;
    int          checkCount = 0;
    int          doneCount = 0;
    int          testErrors = 0;

    signDotTop UUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic fixWord_t saturate(int value);
        if (value > MaxWord) return fixWord_t'(MaxWord);
        if (value < MinWord) return fixWord_t'(MinWord);
        return fixWord_t'(value);
    endfunction

    function automatic fixWord_t smallRand();
        return fixWord_t'(int'(nextRand() & 32'h7ff) - 1024);
    endfunction

    function automatic fixWord_t limitRand();
        logic [31:0] r;
        r = nextRand();
        return r[0] ? fixWord_t'(MaxWord - int'(r[8:1])) : fixWord_t'(MinWord + int'(r[8:1]));
    endfunction

    // Group sums, then the pair sum per step, then the running sum, all saturated
    function automatic fixWord_t modelResult(logic [`COEF_COUNT-1:0] pattern);
        fixWord_t acc;
        int       pair;
        int       part;
        int       j;
        acc = '0;
        for (int s = 0; s < `STEP_COUNT; s++) begin
            pair = 0;
            for (int g = 0; g < `GROUPS_PER_STEP; g++) begin
                part = 0;
                for (int b = 0; b < `LUT_SIZE; b++) begin
                    j = (s * `GROUPS_PER_STEP + g) * `LUT_SIZE + b;
                    part += pattern[j] ? int'(coefModel[j]) : -int'(coefModel[j]);
                end
                pair += int'(saturate(part));
            end
            acc = saturate(int'(acc) + int'(saturate(pair)));
        end
        return acc;
    endfunction

    task automatic waitCoefAck(input logic level);
        int waited;
        waited = 0;
        while (coefAck !== level && waited < HandshakeLimit) begin
            @(negedge clk);
            waited++;
        end
        if (coefAck !== level) begin
            $display("coefAck did not reach %b within %0d cycles", level, HandshakeLimit);
            errorCount++;
        end
    endtask

    // Also flags a coefficient ack that shows up before the compute returns
    task automatic waitDone(input logic level);
        int waited;
        waited = 0;
        while (doneAck !== level && waited < HandshakeLimit) begin
            @(negedge clk);
            waited++;
            if (level && coefAck === 1'b1) begin
                $display("coefAck rose while a compute was busy");
                errorCount++;
            end
        end
        if (doneAck !== level) begin
            $display("doneAck did not reach %b within %0d cycles", level, HandshakeLimit);
            errorCount++;
        end else if (level) begin
            doneCount++;
        end
    endtask

    task automatic writeCoef(input int index, input fixWord_t data);
        @(negedge clk);
        coefReq = 1'b1;
        coefIndex = coefIndex_t'(index);
        coefData = data;
        waitCoefAck(1'b1);
        coefModel[index] = data;
        coefReq = 1'b0;
        waitCoefAck(1'b0);
    endtask

    task automatic checkResult(input fixWord_t expected, input logic [`COEF_COUNT-1:0] pattern);
        checkCount++;
        if (result !== expected) begin
            $display("** Error: result expected %h actual %h, sel %h", expected, result, pattern);
            errorCount++;
        end
    endtask

    task automatic computeOnce(input logic [`COEF_COUNT-1:0] pattern, input int gap);
        fixWord_t expected;
        expected = modelResult(pattern);
        @(negedge clk);
        startReq = 1'b1;
        sel = pattern;
        waitDone(1'b1);
        checkResult(expected, pattern);
        repeat (gap) @(negedge clk);
        startReq = 1'b0;
        waitDone(1'b0);
    endtask

    task automatic endTest(input string name);
        $display("%s: %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    initial begin
        #((OpCount * 40 + 1000) * 10);
        $display("Watchdog expired, the run did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        fixWord_t                expected;
        logic [`COEF_COUNT-1:0] pattern;
        int                      index;
        int                      doneBefore;
        rstPulse = 1'b1;
        coefReq = 1'b0;
        coefIndex = '0;
        coefData = '0;
        startReq = 1'b0;
        sel = '0;
        for (int j = 0; j < `COEF_COUNT; j++) begin
            coefModel[j] = '0;
        end
        repeat (4) @(negedge clk);
        rstPulse = 1'b0;

        if (coefAck !== 1'b0 || doneAck !== 1'b0) begin
            $display("** Error: after reset coefAck %h doneAck %h, expected 0 0", coefAck, doneAck);
            errorCount++;
        end
        computeOnce(`COEF_COUNT'(nextRand()), 0);
        endTest("reset state");

        for (int j = 0; j < `COEF_COUNT; j++) writeCoef(j, smallRand());
        for (int i = 0; i < SmallCount; i++) computeOnce(`COEF_COUNT'(nextRand()), 0);
        endTest("small coefficients");

        // All minimums make the all-minus group wrap inside the table
        for (int j = 0; j < `COEF_COUNT; j++) writeCoef(j, fixWord_t'(MinWord));
        computeOnce('0, 0);
        computeOnce('1, 0);
        for (int j = 0; j < `COEF_COUNT; j++) writeCoef(j, limitRand());
        for (int i = 0; i < LimitCount; i++) begin
            pattern = (i % 4 == 0) ? '0 : (i % 4 == 1) ? '1 : `COEF_COUNT'(nextRand());
            computeOnce(pattern, 0);
        end
        endTest("saturation");

        for (int i = 0; i < RewriteCount; i++) begin
            writeCoef(int'(nextRand() % `COEF_COUNT), (i % 2) ? limitRand() : smallRand());
            computeOnce(`COEF_COUNT'(nextRand()), 0);
        end
        endTest("single rewrites");

        doneBefore = doneCount;
        for (int i = 0; i < BackCount; i++) begin
            computeOnce(`COEF_COUNT'(nextRand()), int'(nextRand() % 4));
        end
        if (doneCount - doneBefore != BackCount) begin
            $display("Lost computes, %0d returned of %0d", doneCount - doneBefore, BackCount);
            errorCount++;
        end
        endTest("back to back");

        for (int i = 0; i < BusyCount; i++) begin
            pattern = `COEF_COUNT'(nextRand());
            index = int'(nextRand() % `COEF_COUNT);
            expected = modelResult(pattern);
            @(negedge clk);
            startReq = 1'b1;
            sel = pattern;
            @(negedge clk);
            coefReq = 1'b1;
            coefIndex = coefIndex_t'(index);
            coefData = smallRand();
            waitDone(1'b1);
            checkResult(expected, pattern);
            startReq = 1'b0;
            waitCoefAck(1'b1);
            coefModel[index] = coefData;
            coefReq = 1'b0;
            waitCoefAck(1'b0);
            waitDone(1'b0);
            computeOnce(`COEF_COUNT'(nextRand()), 0);
        end
        endTest("write during compute");

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
